// ==== Makefile ====
# Verilator build, run and lint for the cube renderer
VERILATOR ?= verilator
TOP       ?= tb_cube_render
RTL_TOP   ?= cube_render_top
FILELIST  ?= cube_render_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0 -Wno-fatal
PASS_MSG  ?= test passed
RTL_SRCS  ?= render_pkg.sv draw_line.sv render_cube_sm.sv clear_screen.sv \
             pixel_merge.sv cube_render_top.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only -Wall -Wno-fatal --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR)

// ==== clear_screen.sv ====
/*
 * screen clearer: emits every canvas pixel in raster order,
 * one per accepted cycle
 */
module clear_screen #(
    parameter int H_RES = 128,
    parameter int V_RES = 96
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  logic               clr_ready,
    output render_pkg::coord_t clr_x,
    output render_pkg::coord_t clr_y,
    output logic               clr_valid,
    output logic               clr_done
);

    localparam render_pkg::coord_t X_LAST = render_pkg::coord_t'(H_RES - 1);
    localparam render_pkg::coord_t Y_LAST = render_pkg::coord_t'(V_RES - 1);

    render_pkg::clear_state_e state;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= render_pkg::CLR_IDLE;
        end else begin
            case (state)
                render_pkg::CLR_IDLE: begin
                    if (start) state <= render_pkg::CLR_RUN;
                end
                render_pkg::CLR_RUN: begin
                    if (clr_ready && clr_x == X_LAST && clr_y == Y_LAST) begin
                        state <= render_pkg::CLR_DONE;
                    end
                end
                default: state <= render_pkg::CLR_IDLE;
            endcase
        end
    end

    // raster counters
    always_ff @(posedge clk) begin
        if (state == render_pkg::CLR_IDLE) begin
            clr_x <= '0;
            clr_y <= '0;
        end else if (state == render_pkg::CLR_RUN && clr_ready) begin
            if (clr_x == X_LAST) begin
                clr_x <= '0;
                clr_y <= clr_y + 16'sd1;
            end else begin
                clr_x <= clr_x + 16'sd1;
            end
        end
    end

    assign clr_valid = (state == render_pkg::CLR_RUN);
    assign clr_done  = (state == render_pkg::CLR_DONE);

endmodule

// ==== cube_render_top.f ====
+incdir+.
render_pkg.sv
draw_line.sv
render_cube_sm.sv
clear_screen.sv
pixel_merge.sv
cube_render_top.sv
tb_cube_render.sv

// ==== cube_render_top.sv ====
/*
 * cube renderer top: screen clearer and cube sequencer merged
 * into one credit-controlled pixel-write port
 */
module cube_render_top #(
    parameter int H_RES   = 128,
    parameter int V_RES   = 96,
    parameter int SCALE   = 1,
    parameter int CREDITS = 4
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  logic               credit_ret,
    output logic               px_valid,
    output render_pkg::coord_t px_x,
    output render_pkg::coord_t px_y,
    output render_pkg::cidx_t  px_cidx,
    output logic               busy,
    output logic               done
);

    logic               clr_valid, clr_ready, clr_done;
    render_pkg::coord_t clr_x, clr_y;
    logic               cube_valid, cube_ready, cube_done;
    render_pkg::coord_t cube_x, cube_y;
    render_pkg::cidx_t  cube_cidx;

    clear_screen #(
        .H_RES (H_RES),
        .V_RES (V_RES)
    ) u_clear_screen (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .clr_ready (clr_ready),
        .clr_x     (clr_x),
        .clr_y     (clr_y),
        .clr_valid (clr_valid),
        .clr_done  (clr_done)
    );

    render_cube_sm #(
        .SCALE (SCALE)
    ) u_render_cube_sm (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .cube_ready (cube_ready),
        .cube_x     (cube_x),
        .cube_y     (cube_y),
        .cube_cidx  (cube_cidx),
        .cube_valid (cube_valid),
        .cube_done  (cube_done)
    );

    pixel_merge #(
        .CREDITS (CREDITS)
    ) u_pixel_merge (
        .clk        (clk),
        .rst        (rst),
        .credit_ret (credit_ret),
        .clr_valid  (clr_valid),
        .clr_x      (clr_x),
        .clr_y      (clr_y),
        .clr_done   (clr_done),
        .cube_valid (cube_valid),
        .cube_x     (cube_x),
        .cube_y     (cube_y),
        .cube_cidx  (cube_cidx),
        .cube_done  (cube_done),
        .clr_ready  (clr_ready),
        .cube_ready (cube_ready),
        .px_valid   (px_valid),
        .px_x       (px_x),
        .px_y       (px_y),
        .px_cidx    (px_cidx),
        .busy       (busy),
        .done       (done)
    );

endmodule

// ==== draw_line.sv ====
/*
 * Bresenham line drawer, one point per cycle while oe is high,
 * both end points included
 */
module draw_line (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  logic               oe,
    input  render_pkg::coord_t x0,
    input  render_pkg::coord_t y0,
    input  render_pkg::coord_t x1,
    input  render_pkg::coord_t y1,
    output render_pkg::coord_t x,
    output render_pkg::coord_t y,
    output logic               drawing,
    output logic               busy,
    output logic               done
);

    localparam int EW = render_pkg::CORDW + 1; // error term width

    render_pkg::line_state_e state;

    logic signed [EW-1:0] dx;  // always >= 0
    logic signed [EW-1:0] dy;  // always <= 0
    logic signed [EW-1:0] err;
    logic signed [EW:0]   e2;  // 2 * err
    logic                 right, down;
    logic                 movx, movy;
    render_pkg::coord_t   xe, ye; // end point

    assign e2   = {err, 1'b0};
    assign movx = (e2 >= dy);
    assign movy = (e2 <= dx);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= render_pkg::LINE_IDLE;
        end else begin
            case (state)
                render_pkg::LINE_IDLE: begin
                    if (start) state <= render_pkg::LINE_INIT0;
                end
                render_pkg::LINE_INIT0: state <= render_pkg::LINE_INIT1;
                render_pkg::LINE_INIT1: state <= render_pkg::LINE_DRAW;
                render_pkg::LINE_DRAW: begin
                    if (oe && x == xe && y == ye) state <= render_pkg::LINE_DONE;
                end
                default: state <= render_pkg::LINE_IDLE; // done lasts one cycle
            endcase
        end
    end

    // datapath, end points are held stable by the sequencer during setup
    always_ff @(posedge clk) begin
        case (state)
            render_pkg::LINE_INIT0: begin
                right <= (x0 < x1);
                down  <= (y0 < y1);
                dx    <= (x0 < x1) ? x1 - x0 : x0 - x1;
                dy    <= (y0 < y1) ? y0 - y1 : y1 - y0; // negative
            end
            render_pkg::LINE_INIT1: begin
                err <= dx + dy;
                x   <= x0;
                y   <= y0;
                xe  <= x1;
                ye  <= y1;
            end
            render_pkg::LINE_DRAW: begin
                if (oe && !(x == xe && y == ye)) begin
                    if (movx) x <= right ? x + 16'sd1 : x - 16'sd1;
                    if (movy) y <= down ? y + 16'sd1 : y - 16'sd1;
                    if (movx && movy) begin
                        err <= err + dy + dx;
                    end else if (movx) begin
                        err <= err + dy;
                    end else if (movy) begin
                        err <= err + dx;
                    end
                end
            end
            default: ;
        endcase
    end

    assign drawing = (state == render_pkg::LINE_DRAW); // point on x, y is valid
    assign busy    = (state != render_pkg::LINE_IDLE);
    assign done    = (state == render_pkg::LINE_DONE);

endmodule

// ==== pixel_merge.sv ====
/*
 * pixel merger: clearer has priority over the cube stream,
 * credit counter throttles writes toward the framebuffer
 */
module pixel_merge #(
    parameter int CREDITS = 4
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               credit_ret,
    input  logic               clr_valid,
    input  render_pkg::coord_t clr_x,
    input  render_pkg::coord_t clr_y,
    input  logic               clr_done,
    input  logic               cube_valid,
    input  render_pkg::coord_t cube_x,
    input  render_pkg::coord_t cube_y,
    input  render_pkg::cidx_t  cube_cidx,
    input  logic               cube_done,
    output logic               clr_ready,
    output logic               cube_ready,
    output logic               px_valid,
    output render_pkg::coord_t px_x,
    output render_pkg::coord_t px_y,
    output render_pkg::cidx_t  px_cidx,
    output logic               busy,
    output logic               done
);

    localparam int CW = $clog2(CREDITS + 1);

    logic [CW-1:0] credit_cnt;
    logic          have_credit;
    logic          clr_seen, cube_seen; // done flags latched per frame
    logic          frame_active;

    assign have_credit = (credit_cnt != '0);

    // clearer first, cube only when the clearer is idle
    assign clr_ready  = have_credit;
    assign cube_ready = have_credit && !clr_valid;
    assign px_valid   = have_credit && (clr_valid || cube_valid);
    assign px_x       = clr_valid ? clr_x : cube_x;
    assign px_y       = clr_valid ? clr_y : cube_y;
    assign px_cidx    = clr_valid ? render_pkg::CLEAR_CIDX : cube_cidx;

    always_ff @(posedge clk) begin
        if (rst) begin
            credit_cnt <= CW'(CREDITS);
        end else if (px_valid && !credit_ret) begin
            credit_cnt <= credit_cnt - 1'b1;
        end else if (!px_valid && credit_ret) begin
            credit_cnt <= credit_cnt + 1'b1;
        end
    end

    // frame completes once both producers have reported done
    assign done = (clr_seen || clr_done) && (cube_seen || cube_done);

    always_ff @(posedge clk) begin
        if (rst || done) begin
            clr_seen  <= 1'b0;
            cube_seen <= 1'b0;
        end else begin
            if (clr_done) clr_seen <= 1'b1;
            if (cube_done) cube_seen <= 1'b1;
        end
    end

    // clearer goes valid the cycle after start, so it marks the frame
    always_ff @(posedge clk) begin
        if (rst || done) begin
            frame_active <= 1'b0;
        end else if (clr_valid) begin
            frame_active <= 1'b1;
        end
    end

    assign busy = frame_active || clr_valid;

endmodule

// ==== render_cube_sm.sv ====
/*
 * cube sequencer: walks the nine scaled cube edges and feeds each one
 * to the line drawer, whose points form the cube pixel stream
 */
module render_cube_sm #(
    parameter int SCALE = 1
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  logic               cube_ready,
    output render_pkg::coord_t cube_x,
    output render_pkg::coord_t cube_y,
    output render_pkg::cidx_t  cube_cidx,
    output logic               cube_valid,
    output logic               cube_done
);

    localparam logic [3:0] LINE_CNT = 4'd9;

    render_pkg::seq_state_e state;

    logic [3:0]         line_id;
    logic [7:0]         ex0, ey0, ex1, ey1; // unscaled edge
    render_pkg::coord_t sx0, sy0, sx1, sy1; // scaled edge
    logic               draw_start;
    logic               line_busy;
    logic               line_done;

    // edge table
    always_comb begin
        case (line_id)
            4'd0: {ex0, ey0, ex1, ey1} = {8'd65, 8'd30, 8'd115, 8'd30};
            4'd1: {ex0, ey0, ex1, ey1} = {8'd115, 8'd30, 8'd115, 8'd80};
            4'd2: {ex0, ey0, ex1, ey1} = {8'd115, 8'd80, 8'd65, 8'd80};
            4'd3: {ex0, ey0, ex1, ey1} = {8'd65, 8'd80, 8'd65, 8'd30};
            4'd4: {ex0, ey0, ex1, ey1} = {8'd65, 8'd80, 8'd45, 8'd60};
            4'd5: {ex0, ey0, ex1, ey1} = {8'd45, 8'd60, 8'd45, 8'd10};
            4'd6: {ex0, ey0, ex1, ey1} = {8'd45, 8'd10, 8'd65, 8'd30};
            4'd7: {ex0, ey0, ex1, ey1} = {8'd45, 8'd10, 8'd95, 8'd10};
            default: {ex0, ey0, ex1, ey1} = {8'd95, 8'd10, 8'd115, 8'd30};
        endcase
    end

    assign sx0 = render_pkg::coord_t'(ex0 * SCALE);
    assign sy0 = render_pkg::coord_t'(ey0 * SCALE);
    assign sx1 = render_pkg::coord_t'(ex1 * SCALE);
    assign sy1 = render_pkg::coord_t'(ey1 * SCALE);

    // first edge starts straight from IDLE, later ones after one INIT cycle
    assign draw_start = !line_busy &&
                        ((state == render_pkg::SEQ_IDLE && start) ||
                         state == render_pkg::SEQ_INIT);

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= render_pkg::SEQ_IDLE;
            line_id <= '0;
        end else begin
            case (state)
                render_pkg::SEQ_IDLE,
                render_pkg::SEQ_INIT: begin
                    if (draw_start) state <= render_pkg::SEQ_DRAW;
                end
                render_pkg::SEQ_DRAW: begin
                    if (line_done) begin
                        if (line_id == LINE_CNT - 4'd1) begin
                            line_id <= '0; // ready for the next frame
                            state   <= render_pkg::SEQ_DONE;
                        end else begin
                            line_id <= line_id + 4'd1;
                            state   <= render_pkg::SEQ_INIT;
                        end
                    end
                end
                default: state <= render_pkg::SEQ_IDLE;
            endcase
        end
    end

    draw_line u_draw_line (
        .clk     (clk),
        .rst     (rst),
        .start   (draw_start),
        .oe      (cube_ready),
        .x0      (sx0),
        .y0      (sy0),
        .x1      (sx1),
        .y1      (sy1),
        .x       (cube_x),
        .y       (cube_y),
        .drawing (cube_valid),
        .busy    (line_busy),
        .done    (line_done)
    );

    assign cube_cidx = render_pkg::CUBE_CIDX;
    assign cube_done = (state == render_pkg::SEQ_DONE);

endmodule

// ==== render_pkg.sv ====
/*
 * render package: coordinate and colour types, FSM state encodings
 * and the colour indices shared by the cube renderer
 */
package render_pkg;

    localparam int CORDW = 16; // signed coordinate width
    localparam int CIDXW = 4;  // colour index width

    typedef logic signed [CORDW-1:0] coord_t;
    typedef logic [CIDXW-1:0] cidx_t;

    localparam cidx_t CLEAR_CIDX = 4'd0; // background
    localparam cidx_t CUBE_CIDX  = 4'd2; // cube edges

    // line drawer FSM
    typedef enum logic [2:0] {
        LINE_IDLE,
        LINE_INIT0, // directions and deltas
        LINE_INIT1, // error term and start point
        LINE_DRAW,
        LINE_DONE
    } line_state_e;

    // cube sequencer FSM
    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_INIT,
        SEQ_DRAW,
        SEQ_DONE
    } seq_state_e;

    // screen clearer FSM
    typedef enum logic [1:0] {
        CLR_IDLE,
        CLR_RUN,
        CLR_DONE
    } clear_state_e;

endpackage

// ==== tb_cube_ref.svh ====
/*
 * reference model: expected pixel list of the clear pass
 * followed by the Bresenham points of the nine cube edges
 */

function automatic void push_px(int x, int y, render_pkg::cidx_t c);
    exp_x.push_back(render_pkg::coord_t'(x));
    exp_y.push_back(render_pkg::coord_t'(y));
    exp_c.push_back(c);
endfunction

// unscaled cube edges in drawing order
function automatic void cube_edge(input int idx, output int x0, output int y0,
                                  output int x1, output int y1);
    int e[4];
    case (idx)
        0:       e = '{65, 30, 115, 30};
        1:       e = '{115, 30, 115, 80};
        2:       e = '{115, 80, 65, 80};
        3:       e = '{65, 80, 65, 30};
        4:       e = '{65, 80, 45, 60};
        5:       e = '{45, 60, 45, 10};
        6:       e = '{45, 10, 65, 30};
        7:       e = '{45, 10, 95, 10};
        default: e = '{95, 10, 115, 30};
    endcase
    x0 = e[0];
    y0 = e[1];
    x1 = e[2];
    y1 = e[3];
endfunction

function automatic void add_clear_pass();
    for (int y = 0; y < V_RES; y++) begin
        for (int x = 0; x < H_RES; x++) begin
            push_px(x, y, render_pkg::CLEAR_CIDX);
        end
    end
endfunction

// textbook Bresenham, both end points included
function automatic void add_line(int x0, int y0, int x1, int y1);
    int x, y, dx, dy, sx, sy, err, e2;
    bit at_end;
    x      = x0;
    y      = y0;
    dx     = (x1 > x0) ? x1 - x0 : x0 - x1;
    dy     = (y1 > y0) ? y0 - y1 : y1 - y0; // kept negative
    sx     = (x1 > x0) ? 1 : -1;
    sy     = (y1 > y0) ? 1 : -1;
    err    = dx + dy;
    at_end = 1'b0;
    while (!at_end) begin
        push_px(x, y, render_pkg::CUBE_CIDX);
        if (x == x1 && y == y1) begin
            at_end = 1'b1;
        end else begin
            e2 = 2 * err;
            if (e2 >= dy) begin
                err += dy;
                x   += sx;
            end
            if (e2 <= dx) begin
                err += dx;
                y   += sy;
            end
        end
    end
endfunction

function automatic void build_frame();
    int x0, y0, x1, y1;
    add_clear_pass();
    for (int i = 0; i < 9; i++) begin
        cube_edge(i, x0, y0, x1, y1);
        add_line(x0 * SCALE, y0 * SCALE, x1 * SCALE, y1 * SCALE);
    end
endfunction

// ==== tb_cube_render.sv ====
/*
 * testbench for the cube renderer: credit-returning sink with stalls,
 * two frames checked pixel by pixel against the reference sequence
 */
module tb_cube_render;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int H_RES      = 128;
    localparam int V_RES      = 96;
    localparam int SCALE      = 1;
    localparam int CREDITS    = 4;
    localparam int MAX_DELAY  = 5;  // credit return delay in cycles
    localparam int HOLD_CYC   = 30; // sink stall length
    localparam int LINE_SETUP = 3;
    localparam int FRAMES     = 2;
    localparam int SEED       = 32'hdf40e391;

    logic               clk, rst, start, credit_ret;
    logic               px_valid, busy, done;
    render_pkg::coord_t px_x, px_y;
    render_pkg::cidx_t  px_cidx;

    render_pkg::coord_t exp_x[$], exp_y[$];
    render_pkg::cidx_t  exp_c[$];
    int                 frame_len = 0;
    int                 frames_started = 0;
    int                 frames_done = 0;
    int                 sent_cnt = 0;
    int                 ret_cnt = 0;

    `include "tb_cube_ref.svh"

    cube_render_top #(
        .H_RES   (H_RES),
        .V_RES   (V_RES),
        .SCALE   (SCALE),
        .CREDITS (CREDITS)
    ) uut (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .credit_ret (credit_ret),
        .px_valid   (px_valid),
        .px_x       (px_x),
        .px_y       (px_y),
        .px_cidx    (px_cidx),
        .busy       (busy),
        .done       (done)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_with_error(string line);
        $display("%s", line);
        $display("test failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_coord(string name, render_pkg::coord_t got, render_pkg::coord_t exp);
        if (got !== exp) begin
            stop_with_error($sformatf("Mismatch at %0t ns: %s got %0d expected %0d",
                                      $time, name, got, exp));
        end
    endtask

    task automatic check_cidx(string name, render_pkg::cidx_t got, render_pkg::cidx_t exp);
        if (got !== exp) begin
            stop_with_error($sformatf("Mismatch at %0t ns: %s got %0d expected %0d",
                                      $time, name, got, exp));
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            stop_with_error($sformatf("Mismatch at %0t ns: %s got %b expected %b",
                                      $time, name, got, exp));
        end
    endtask

    task automatic check_credit(int outstanding);
        if (outstanding > CREDITS) begin
            stop_with_error($sformatf(
                "pixel sent with no credit at %0t ns, %0d outstanding, limit %0d",
                $time, outstanding, CREDITS));
        end
    endtask

    // outputs settle after the rising edge, inputs move on the falling one
    task automatic next_sample();
        @(posedge clk);
        #1;
    endtask

    initial begin : main_seq
        rst   = 1'b1;
        start = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        repeat (10) begin // quiet until start
            next_sample();
            check_bit("px_valid", px_valid, 1'b0);
            check_bit("busy", busy, 1'b0);
            check_bit("done", done, 1'b0);
        end
        for (int f = 0; f < FRAMES; f++) begin
            build_frame();
            frame_len = exp_x.size();
            @(negedge clk);
            start = 1'b1;
            frames_started++;
            @(negedge clk);
            start = 1'b0;
            wait (frames_done == f + 1);
            repeat (20) begin
                next_sample();
                check_bit("busy", busy, 1'b0);
            end
        end
        $display("test passed");
        $finish;
    end

    initial begin : credit_sink
        int due_q[$]; // cycle in which each credit goes back
        int cyc;
        int hold_cnt;
        credit_ret = 1'b0;
        cyc        = 0;
        hold_cnt   = 0;
        void'($urandom(SEED));
        forever begin
            next_sample();
            cyc++;
            if (px_valid === 1'b1) begin
                sent_cnt++;
                check_credit(sent_cnt - ret_cnt);
                due_q.push_back(cyc + 1 + $urandom_range(MAX_DELAY, 0));
                // one stall in the clear pass, one in the cube pass
                if (sent_cnt % frame_len == 200 ||
                    sent_cnt % frame_len == H_RES * V_RES + 30) begin
                    hold_cnt = HOLD_CYC;
                end
            end
            @(negedge clk);
            credit_ret = 1'b0;
            if (hold_cnt > 0) begin
                hold_cnt--;
            end else begin
                for (int i = 0; i < due_q.size(); i++) begin
                    if (!credit_ret && due_q[i] <= cyc) begin
                        due_q.delete(i);
                        credit_ret = 1'b1; // one credit per cycle
                        ret_cnt++;
                    end
                end
            end
        end
    end

    initial begin : pixel_checker
        bit busy_low_next;
        bit in_frame;
        busy_low_next = 1'b0;
        forever begin
            next_sample();
            in_frame = (frames_started != frames_done);
            if (busy_low_next) check_bit("busy", busy, 1'b0);
            busy_low_next = 1'b0;
            if (in_frame) check_bit("busy", busy, 1'b1);
            if (px_valid === 1'b1) begin
                if (exp_x.size() == 0) begin
                    stop_with_error("pixel written beyond the expected sequence");
                end else begin
                    check_coord("px_x", px_x, exp_x.pop_front());
                    check_coord("px_y", px_y, exp_y.pop_front());
                    check_cidx("px_cidx", px_cidx, exp_c.pop_front());
                end
            end
            if (done === 1'b1) begin
                if (!in_frame) begin
                    stop_with_error("done pulsed with no frame in progress");
                end else if (exp_x.size() != 0) begin
                    stop_with_error($sformatf("done pulsed with %0d pixels still expected",
                                              exp_x.size()));
                end else begin
                    frames_done++;
                    busy_low_next = 1'b1; // busy drops with done
                end
            end
        end
    end

    initial begin : watchdog
        int limit;
        wait (frame_len > 0);
        limit = FRAMES * (frame_len * (MAX_DELAY + 2) + 9 * LINE_SETUP + 2 * HOLD_CYC) + 100;
        repeat (limit) @(posedge clk);
        stop_with_error($sformatf("timeout: frames not finished after %0d cycles", limit));
    end

endmodule
